// File: coreMemWrap.f
+incdir+rtl
+incdir+dv
rtl/fabricPkg.sv
rtl/corePkg.sv
rtl/dualPortRam.sv
rtl/transFifo.sv
rtl/coreAccess.sv
rtl/fabricSlave.sv
rtl/fabricEgress.sv
rtl/coreMemWrap.sv
dv/coreMemWrapTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and succeed only when the pass line is printed
cd "$(dirname "$0")" \
   && verilator --binary --timing --top-module coreMemWrapTb -f coreMemWrap.f -o coreMemWrapSim \
   && ./obj_dir/coreMemWrapSim | tee /dev/stderr | grep -qx "STATUS: PASS" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: build or simulation failed"; exit 1; }

// File: dv/coreMemWrapTests.svh
// Directed tests, included inside the testbench module; tests rely on running in the listed order
`ifndef CORE_MEM_WRAP_TESTS_SVH
`define CORE_MEM_WRAP_TESTS_SVH

// ============================================================
// Stimulus helpers
// ============================================================
function automatic fabricPkg::tFabAddr tileAddr(input logic [`TILE_ID_W-1:0] tile,
                                                input logic [23:0] offset);
   fabricPkg::tFabAddr a;
   a.tileView.tileId = tile;
   a.tileView.offset = offset;
   return a;
endfunction

function automatic fabricPkg::tFabAddr regionAddr(input logic [`TILE_ID_W-1:0] tile,
   input logic [3:0] region, input logic [9:0] idx, input logic [1:0] sel);
   fabricPkg::tFabAddr a;
   a = '0;                               // Spare bits stay zero
   a.regionView.tileId  = tile;
   a.regionView.region  = region;
   a.regionView.wordIdx = idx;
   a.regionView.byteSel = sel;
   return a;
endfunction

function automatic fabricPkg::tTileTrans makeTrans(input fabricPkg::tFabAddr addr,
   input logic [`DATA_W-1:0] data, input fabricPkg::tFabOpcode op,
   input logic [`TILE_ID_W-1:0] reqId);
   fabricPkg::tTileTrans t;
   t.address     = addr;
   t.data        = data;
   t.opcode      = op;
   t.requestorId = reqId;
   return t;
endfunction

// Model word read at sel, right-aligned, upper bytes zero
function automatic logic [`DATA_W-1:0] alignedWord(input logic [9:0] idx, input logic [1:0] sel);
   logic [`DATA_W-1:0] w;
   w = '0;
   for (int b = 0; b + sel < 4; b++)
      w[b*8 +: 8] = dMemModel[idx][(b + sel)*8 +: 8];
   return w;
endfunction

task automatic fabricPulse(input fabricPkg::tTileTrans t);
   @(posedge Clock);
   inFabricValid <= 1'b1;
   inFabric      <= t;
   @(posedge Clock);
   inFabricValid <= 1'b0;
endtask

// Pc held two cycles, word checked one cycle after it was presented
task automatic fetchCheck(input logic [9:0] idx, input logic ready,
                          input logic [`DATA_W-1:0] exp);
   fabricPkg::tFabAddr pc;
   pc = regionAddr(8'h00, `REGION_IMEM, idx, 2'd0);
   @(posedge Clock);
   fetch.pc    <= pc;
   fetch.ready <= ready;
   @(posedge Clock);
   @(negedge Clock);
   checkWord("instruction", instruction, exp);
endtask

task automatic coreWrite(input logic [9:0] idx, input logic [1:0] sel, input logic [3:0] en,
                         input logic [`DATA_W-1:0] data, input logic [`TILE_ID_W-1:0] tile);
   corePkg::tDMemReq req;
   req        = '0;
   req.addr   = regionAddr(tile, `REGION_DMEM, idx, sel);
   req.wrData = data;
   req.byteEn = en;
   req.wrEn   = 1'b1;
   for (int k = 0; k + sel < 4; k++)        // Source byte k lands in lane k+sel
      if (en[k]) dMemModel[idx][(k + sel)*8 +: 8] = data[k*8 +: 8];
   @(posedge Clock);
   dReq <= req;
   @(posedge Clock);
   dReq <= '0;
endtask

// One-cycle read, response due two cycles after it
task automatic readCheck(input fabricPkg::tFabAddr addr, input logic [`DATA_W-1:0] exp);
   corePkg::tDMemReq req;
   req      = '0;
   req.addr = addr;
   req.rdEn = 1'b1;
   @(posedge Clock);
   dReq <= req;
   @(posedge Clock);
   dReq <= '0;
   @(posedge Clock);
   @(negedge Clock);
   checkWord("dMemRdRsp", dMemRdRsp, exp);
endtask

task automatic waitOutValid(input string what);
   int n;
   n = 0;
   @(negedge Clock);
   while (outFabricValid !== 1'b1 && n < waitLimit) begin
      @(negedge Clock);
      n++;
   end
   if (outFabricValid !== 1'b1) begin
      errorCount++;
      $display("no fabric output for the %s within %0d cycles", what, waitLimit);
   end
endtask

// ============================================================
// Tests
// ============================================================
task automatic testResetState();
   beginTest();
   @(negedge Clock);
   checkBit("outFabricValid", outFabricValid, 1'b0);
   checkBit("dMemReady", dMemReady, 1'b1);
   checkBit("fabricReady", fabricReady, 1'b1);
   endTest("resetState");
endtask

task automatic testImemFetch();
   logic [9:0]         idx [4];
   logic [`DATA_W-1:0] word;
   beginTest();
   for (int i = 0; i < 4; i++) begin
      idx[i] = 10'(i * 37 + 5);
      word   = $random(seed);
      iMemModel[idx[i]] = word;
      fabricPulse(makeTrans(regionAddr(ownTile, `REGION_IMEM, idx[i], 2'd0), word,
                            fabricPkg::WR, 8'h11));
   end
   for (int i = 0; i < 4; i++)
      fetchCheck(idx[i], 1'b1, iMemModel[idx[i]]);
   fetchCheck(idx[0], 1'b0, iMemModel[idx[3]]);   // Stalled, last ready word stays
   fetchCheck(idx[1], 1'b0, iMemModel[idx[3]]);
   fetchCheck(idx[2], 1'b1, iMemModel[idx[2]]);   // Released
   endTest("imemFetch");
endtask

task automatic testLocalData();
   logic [`DATA_W-1:0] r;
   logic [9:0]         idx;
   logic [1:0]         sel;
   beginTest();
   for (int i = 0; i < 4; i++) begin      // Full words first, every lane known
      r = $random(seed);
      coreWrite(10'(100 + i), 2'd0, 4'hF, r, ownTile);
   end
   for (int i = 0; i < 8; i++) begin
      r   = $random(seed);
      idx = 10'(100 + i % 4);
      sel = 2'(i);
      coreWrite(idx, sel, (i < 4) ? 4'b0001 : 4'b0011, r, (i % 2 == 0) ? ownTile : 8'h00);
      readCheck(regionAddr(8'h00, `REGION_DMEM, idx, sel), alignedWord(idx, sel));
      readCheck(regionAddr(ownTile, `REGION_DMEM, idx, 2'd0), alignedWord(idx, 2'd0));
   end
   endTest("localData");
endtask

task automatic testWhoAmI();
   logic [`DATA_W-1:0] exp;
   beginTest();
   exp = '0;
   exp[`TILE_ID_W-1:0] = ownTile;        // Zero-extended id
   readCheck(tileAddr(8'h00, `WHOAMI_OFFSET), exp);
   endTest("whoAmI");
endtask

task automatic testFabricRead();
   logic [`DATA_W-1:0]   word;
   fabricPkg::tFabAddr   addr;
   fabricPkg::tTileTrans exp;
   beginTest();
   word = $random(seed);
   addr = regionAddr(ownTile, `REGION_DMEM, 10'd321, 2'd0);
   dMemModel[321] = word;
   fabricPulse(makeTrans(addr, word, fabricPkg::WR, 8'h05));
   fabricPulse(makeTrans(addr, '0, fabricPkg::RD, 8'h05));
   exp = makeTrans(tileAddr(8'h05, addr.tileView.offset), dMemModel[321],
                   fabricPkg::RD_RSP, ownTile);
   waitOutValid("read response");
   checkTrans("outFabric", outFabric, exp);
   lastOutWasReq = 1'b0;
   @(negedge Clock);
   checkBit("outFabricValid", outFabricValid, 1'b0);   // Sent once only
   endTest("fabricRead");
endtask

task automatic testRemoteRead();
   corePkg::tDMemReq     req;
   fabricPkg::tTileTrans exp;
   logic [`DATA_W-1:0]   rspData;
   beginTest();
   req      = '0;
   req.addr = tileAddr(8'h07, 24'h000410);
   req.rdEn = 1'b1;
   exp      = makeTrans(req.addr, '0, fabricPkg::RD, ownTile);
   @(posedge Clock);
   dReq <= req;                          // Held while the core is stalled
   waitOutValid("remote read");
   checkTrans("outFabric", outFabric, exp);
   lastOutWasReq = 1'b1;
   repeat (2) begin
      checkBit("dMemReady", dMemReady, 1'b0);
      @(negedge Clock);
   end
   rspData = $random(seed);
   @(posedge Clock);
   dReq          <= '0;
   inFabricValid <= 1'b1;
   inFabric      <= makeTrans(tileAddr(ownTile, 24'h000410), rspData, fabricPkg::RD_RSP, 8'h07);
   @(posedge Clock);
   inFabricValid <= 1'b0;
   @(negedge Clock);
   checkBit("dMemReady", dMemReady, 1'b1);
   @(negedge Clock);
   checkWord("dMemRdRsp", dMemRdRsp, rspData);
   endTest("remoteRead");
endtask

task automatic testBackPressure();
   corePkg::tDMemReq     req;
   fabricPkg::tFabAddr   rdAddr;
   fabricPkg::tTileTrans expRsp;
   fabricPkg::tTileTrans expReq;
   beginTest();
   rdAddr     = regionAddr(ownTile, `REGION_DMEM, 10'd321, 2'd0);
   req        = '0;
   req.addr   = tileAddr(8'h09, 24'h000080);
   req.wrData = $random(seed);
   req.byteEn = 4'hF;
   req.wrEn   = 1'b1;
   expRsp = makeTrans(tileAddr(8'h03, rdAddr.tileView.offset), dMemModel[321],
                      fabricPkg::RD_RSP, ownTile);
   expReq = makeTrans(req.addr, req.wrData, fabricPkg::WR, ownTile);
   @(posedge Clock);
   fabReady      <= 4'b1011;             // One link stalled
   dReq          <= req;
   inFabricValid <= 1'b1;
   inFabric      <= makeTrans(rdAddr, '0, fabricPkg::RD, 8'h03);
   @(posedge Clock);
   dReq          <= '0;
   inFabricValid <= 1'b0;
   repeat (4) begin
      @(negedge Clock);
      checkBit("outFabricValid", outFabricValid, 1'b0);
   end
   checkBit("fabricReady", fabricReady, 1'b0);   // Response queue at its margin
   @(posedge Clock);
   fabReady <= 4'b1111;
   waitOutValid("first queued transaction");
   checkTrans("outFabric", outFabric, lastOutWasReq ? expRsp : expReq);
   @(negedge Clock);
   checkBit("outFabricValid", outFabricValid, 1'b1);
   checkTrans("outFabric", outFabric, lastOutWasReq ? expReq : expRsp);
   @(negedge Clock);
   checkBit("outFabricValid", outFabricValid, 1'b0);
   checkBit("fabricReady", fabricReady, 1'b1);
   endTest("backPressure");
endtask

`endif

// File: dv/coreMemWrapTb.sv
// Tile id is fixed at 2A; memory contents are compared only at addresses the tests wrote first
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module coreMemWrapTb;

   // ============================================================
   // Timing budget
   // ============================================================
   localparam int clkPeriod   = 10;
   localparam int waitLimit   = 20;      // Cycles allowed for one fabric output
   // Reset, then each test in order, with every output wait at its limit
   localparam int cycleBudget = 5 + 1 + 22 + 88 + 4 + (6 + waitLimit) + (8 + waitLimit)
                                + (10 + waitLimit);
   localparam int watchdogNs  = 2 * cycleBudget * clkPeriod;
   localparam logic [`TILE_ID_W-1:0] ownTile = 8'h2A;

   logic                  Clock;
   logic                  rstN;
   logic [`TILE_ID_W-1:0] tileId;
   corePkg::tFetchReq     fetch;
   logic [`DATA_W-1:0]    instruction;
   corePkg::tDMemReq      dReq;
   logic [`DATA_W-1:0]    dMemRdRsp;
   logic                  dMemReady;
   logic                  inFabricValid;
   fabricPkg::tTileTrans  inFabric;
   logic                  fabricReady;
   logic                  outFabricValid;
   fabricPkg::tTileTrans  outFabric;
   fabricPkg::tFabReady   fabReady;

   // Reference memories, written by the same lane rules as the wrapper
   logic [`DATA_W-1:0] iMemModel [2**`IMEM_IDX_W];
   logic [`DATA_W-1:0] dMemModel [2**`DMEM_IDX_W];
   integer seed = 32'h3a5e5620;
   int     errorCount;
   int     checkCount;
   int     testCount;
   int     testErrors;          // errorCount when the current test began
   logic   lastOutWasReq;       // Last egress winner was the request queue

   initial Clock = 1'b0;
   always #(clkPeriod / 2) Clock = ~Clock;

   coreMemWrap i_coreMemWrap (.*);

   // ============================================================
   // Compare tasks
   // ============================================================
   task automatic checkWord(input string name, input logic [`DATA_W-1:0] got,
                            input logic [`DATA_W-1:0] exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkTrans(input string name, input fabricPkg::tTileTrans got,
                             input fabricPkg::tTileTrans exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic beginTest();
      testErrors = errorCount;
   endtask

   task automatic endTest(input string name);
      testCount++;
      if (errorCount == testErrors) $display("test %-14s ok", name);
      else $display("test %-14s %0d errors", name, errorCount - testErrors);
   endtask

   `include "coreMemWrapTests.svh"

   // Hard stop if a wait never returns
   initial begin
      #(watchdogNs);
      $display("watchdog expired after %0d ns, the tests did not finish", watchdogNs);
      $display("STATUS: FAIL");
      $finish;
   end

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      rstN          = 1'b0;
      tileId        = ownTile;
      fetch         = '0;
      fetch.ready   = 1'b1;
      dReq          = '0;
      inFabricValid = 1'b0;
      inFabric      = '0;
      fabReady      = '1;
      errorCount    = 0;
      checkCount    = 0;
      testCount     = 0;
      testErrors    = 0;
      lastOutWasReq = 1'b1;            // Arbiter favours responses out of reset
      repeat (5) @(posedge Clock);
      rstN <= 1'b1;
      testResetState();
      testImemFetch();
      testLocalData();
      testWhoAmI();
      testFabricRead();
      testRemoteRead();
      testBackPressure();
      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: rtl/coreMemWrap.sv
// Single tile memory wrapper; instruction memory is written only from the fabric
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module coreMemWrap (
   input  logic                  Clock,
   input  logic                  rstN,
   input  logic [`TILE_ID_W-1:0] tileId,
   input  corePkg::tFetchReq     fetch,
   output logic [`DATA_W-1:0]    instruction,
   input  corePkg::tDMemReq      dReq,
   output logic [`DATA_W-1:0]    dMemRdRsp,
   output logic                  dMemReady,
   input  logic                  inFabricValid,
   input  fabricPkg::tTileTrans  inFabric,
   output logic                  fabricReady,
   output logic                  outFabricValid,
   output fabricPkg::tTileTrans  outFabric,
   input  fabricPkg::tFabReady   fabReady
);

   fabricPkg::tFabAddr     pcAddr;       // pc in region view
   logic [`DATA_W-1:0]     instrRaw;
   logic [`DATA_W-1:0]     iRamRdDataB;
   logic [`DATA_W-1:0]     dRamRdDataA;
   logic [`DATA_W-1:0]     dRamRdDataB;
   logic [`DMEM_IDX_W-1:0] dRamIdx;
   logic [`DATA_W-1:0]     dRamWrData;
   logic [3:0]             dRamByteEn;
   logic                   dRamWrEnA;
   logic [9:0]             ramIdxB;
   logic [`DATA_W-1:0]     ramWrDataB;
   logic                   iRamWrEnB;
   logic                   dRamWrEnB;
   logic                   rspPush;
   fabricPkg::tTileTrans   rspTrans;
   logic                   c2fPush;
   fabricPkg::tTileTrans   c2fReq;
   logic                   c2fFull;

   assign pcAddr = fetch.pc;

   // ============================================================
   // Memories, port a core, port b fabric
   // ============================================================
   dualPortRam #(.idxW(`IMEM_IDX_W)) iMem (
      .Clock(Clock), .idxA(pcAddr.regionView.wordIdx), .idxB(ramIdxB),
      .wrDataA('0), .wrDataB(ramWrDataB), .byteEnA(4'b0000), .byteEnB(4'b1111),
      .wrEnA(1'b0), .wrEnB(iRamWrEnB), .rdDataA(instrRaw), .rdDataB(iRamRdDataB)
   );

   dualPortRam #(.idxW(`DMEM_IDX_W)) dMem (
      .Clock(Clock), .idxA(dRamIdx), .idxB(ramIdxB),
      .wrDataA(dRamWrData), .wrDataB(ramWrDataB), .byteEnA(dRamByteEn), .byteEnB(4'b1111),
      .wrEnA(dRamWrEnA), .wrEnB(dRamWrEnB), .rdDataA(dRamRdDataA), .rdDataB(dRamRdDataB)
   );

   coreAccess uCoreAccess (
      .Clock(Clock), .rstN(rstN), .tileId(tileId),
      .fetch(fetch), .instrRaw(instrRaw), .instruction(instruction),
      .dReq(dReq), .dRamRdData(dRamRdDataA), .dRamIdx(dRamIdx),
      .dRamWrData(dRamWrData), .dRamByteEn(dRamByteEn), .dRamWrEn(dRamWrEnA),
      .c2fPush(c2fPush), .c2fReq(c2fReq), .c2fFull(c2fFull),
      .inFabricValid(inFabricValid), .inFabric(inFabric),
      .dMemRdRsp(dMemRdRsp), .dMemReady(dMemReady)
   );

   fabricSlave uFabricSlave (
      .Clock(Clock), .rstN(rstN), .tileId(tileId),
      .inFabricValid(inFabricValid), .inFabric(inFabric),
      .ramIdx(ramIdxB), .ramWrData(ramWrDataB),
      .iRamWrEn(iRamWrEnB), .dRamWrEn(dRamWrEnB),
      .iRamRdData(iRamRdDataB), .dRamRdData(dRamRdDataB),
      .rspPush(rspPush), .rspTrans(rspTrans)
   );

   fabricEgress uFabricEgress (
      .Clock(Clock), .rstN(rstN),
      .rspPush(rspPush), .rspTrans(rspTrans),
      .c2fPush(c2fPush), .c2fReq(c2fReq), .c2fFull(c2fFull),
      .fabReady(fabReady), .fabricReady(fabricReady),
      .outFabricValid(outFabricValid), .outFabric(outFabric)
   );

endmodule

// File: rtl/fabricEgress.sv
// Waits for every fabReady bit, not just the target link; one transaction leaves per cycle
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module fabricEgress (
   input  logic                 Clock,
   input  logic                 rstN,
   input  logic                 rspPush,
   input  fabricPkg::tTileTrans rspTrans,
   input  logic                 c2fPush,
   input  fabricPkg::tTileTrans c2fReq,
   output logic                 c2fFull,
   input  fabricPkg::tFabReady  fabReady,
   output logic                 fabricReady,
   output logic                 outFabricValid,
   output fabricPkg::tTileTrans outFabric
);

   fabricPkg::tTileTrans rspHead;
   fabricPkg::tTileTrans reqHead;
   logic                 rspEmpty;
   logic                 reqEmpty;
   logic                 rspAlmostFull;
   logic [1:0]           cand;         // 0 response, 1 request
   logic [1:0]           grant;
   logic                 lastWinner;

   // Read responses to the fabric
   transFifo #(.depth(`QUEUE_DEPTH)) rspQueue (
      .Clock      (Clock),
      .rstN       (rstN),
      .push       (rspPush),
      .pushData   (rspTrans),
      .pop        (grant[0]),
      .popData    (rspHead),
      .full       (),
      .almostFull (rspAlmostFull),
      .empty      (rspEmpty)
   );

   // Remote core requests
   transFifo #(.depth(`QUEUE_DEPTH)) reqQueue (
      .Clock      (Clock),
      .rstN       (rstN),
      .push       (c2fPush),
      .pushData   (c2fReq),
      .pop        (grant[1]),
      .popData    (reqHead),
      .full       (c2fFull),
      .almostFull (),
      .empty      (reqEmpty)
   );

   // ============================================================
   // Round-robin arbiter
   // ============================================================
   assign cand[0] = !rspEmpty && (&fabReady);
   assign cand[1] = !reqEmpty && (&fabReady);

   always_comb begin
      if (&cand) grant = lastWinner ? 2'b01 : 2'b10;   // Both, alternate
      else       grant = cand;
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN)       lastWinner <= 1'b1;       // Responses go first
      else if (|grant) lastWinner <= grant[1];
   end

   assign outFabricValid = |grant;
   assign outFabric      = grant[0] ? rspHead :
                           grant[1] ? reqHead : '0;
   assign fabricReady    = !rspAlmostFull;       // Keep one slot of margin

endmodule

// File: rtl/fabricSlave.sv
// Fabric writes are full words; region codes other than IMEM and DMEM read back as zero
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module fabricSlave (
   input  logic                  Clock,
   input  logic                  rstN,
   input  logic [`TILE_ID_W-1:0] tileId,
   input  logic                  inFabricValid,
   input  fabricPkg::tTileTrans  inFabric,
   output logic [9:0]            ramIdx,
   output logic [`DATA_W-1:0]    ramWrData,
   output logic                  iRamWrEn,
   output logic                  dRamWrEn,
   input  logic [`DATA_W-1:0]    iRamRdData,
   input  logic [`DATA_W-1:0]    dRamRdData,
   output logic                  rspPush,
   output fabricPkg::tTileTrans  rspTrans
);

   logic               iHit;
   logic               dHit;
   logic               isWr;
   logic               isRd;
   logic               iHitQ;
   logic               dHitQ;
   logic               rdValidQ;    // Read accepted last cycle
   fabricPkg::tFabAddr rspAddrQ;

   // ============================================================
   // Inbound decode
   // ============================================================
   assign iHit = (inFabric.address.regionView.region == `REGION_IMEM);
   assign dHit = (inFabric.address.regionView.region == `REGION_DMEM);
   assign isWr = inFabricValid && (inFabric.opcode == fabricPkg::WR);
   assign isRd = inFabricValid && (inFabric.opcode == fabricPkg::RD);

   assign ramIdx    = inFabric.address.regionView.wordIdx;   // Shared by both memories
   assign ramWrData = inFabric.data;
   assign iRamWrEn  = iHit && isWr;
   assign dRamWrEn  = dHit && isWr;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         rdValidQ <= 1'b0;
         iHitQ    <= 1'b0;
         dHitQ    <= 1'b0;
      end else begin
         rdValidQ <= isRd;
         iHitQ    <= iHit;
         dHitQ    <= dHit;
      end
   end

   // Response goes back to the requestor, same offset
   always_ff @(posedge Clock) begin
      rspAddrQ.tileView.tileId <= inFabric.requestorId;
      rspAddrQ.tileView.offset <= inFabric.address.tileView.offset;
   end

   // ============================================================
   // Read response build
   // ============================================================
   assign rspPush              = rdValidQ;
   assign rspTrans.address     = rspAddrQ;
   assign rspTrans.opcode      = fabricPkg::RD_RSP;
   assign rspTrans.requestorId = tileId;
   assign rspTrans.data        = iHitQ ? iRamRdData :
                                 dHitQ ? dRamRdData : '0;

endmodule

// File: rtl/coreAccess.sv
// One remote read in flight at most; the core must hold its request while dMemReady is low
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module coreAccess (
   input  logic                    Clock,
   input  logic                    rstN,
   input  logic [`TILE_ID_W-1:0]   tileId,
   input  corePkg::tFetchReq       fetch,
   input  logic [`DATA_W-1:0]      instrRaw,
   output logic [`DATA_W-1:0]      instruction,
   input  corePkg::tDMemReq        dReq,
   input  logic [`DATA_W-1:0]      dRamRdData,
   output logic [`DMEM_IDX_W-1:0]  dRamIdx,
   output logic [`DATA_W-1:0]      dRamWrData,
   output logic [3:0]              dRamByteEn,
   output logic                    dRamWrEn,
   output logic                    c2fPush,
   output fabricPkg::tTileTrans    c2fReq,
   input  logic                    c2fFull,
   input  logic                    inFabricValid,
   input  fabricPkg::tTileTrans    inFabric,
   output logic [`DATA_W-1:0]      dMemRdRsp,
   output logic                    dMemReady
);

   logic               readyQ;          // fetch.ready, one cycle late
   logic [`DATA_W-1:0] lastInstrQ;
   logic               isLocal;
   logic               isWhoAmI;
   logic               isRemote;
   logic               outstanding;     // Remote read in flight
   logic               rspValid;
   logic               rspValidQ;
   logic [`DATA_W-1:0] rspDataQ;
   logic               whoAmIQ;
   logic [1:0]         byteSelQ;
   logic               sampleReadyQ;    // dMemReady, one cycle late
   logic [`DATA_W-1:0] lastRamQ;
   logic [`DATA_W-1:0] ramWord;
   logic [`DATA_W-1:0] preRsp;

   // ============================================================
   // Fetch hold
   // ============================================================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) readyQ <= 1'b1;
      else       readyQ <= fetch.ready;
   end

   always_ff @(posedge Clock) begin
      if (readyQ) lastInstrQ <= instrRaw;   // Last word fetched under ready
   end

   assign instruction = readyQ ? instrRaw : lastInstrQ;

   // ============================================================
   // Request classification
   // ============================================================
   assign isLocal  = (dReq.addr.tileView.tileId == '0) || (dReq.addr.tileView.tileId == tileId);
   assign isWhoAmI = (dReq.addr.tileView.tileId == '0) &&
                     (dReq.addr.tileView.offset == `WHOAMI_OFFSET) && dReq.rdEn;
   assign isRemote = (dReq.wrEn || dReq.rdEn) && !isLocal;

   // Local write, shifted into its byte lanes
   assign dRamIdx    = dReq.addr.regionView.wordIdx;
   assign dRamWrData = dReq.wrData << {dReq.addr.regionView.byteSel, 3'b000};
   assign dRamByteEn = dReq.byteEn << dReq.addr.regionView.byteSel;
   assign dRamWrEn   = dReq.wrEn && isLocal;

   // Remote request toward the fabric
   assign c2fPush            = isRemote && !outstanding;
   assign c2fReq.address     = dReq.addr;
   assign c2fReq.data        = dReq.wrData;
   assign c2fReq.opcode      = dReq.wrEn ? fabricPkg::WR : fabricPkg::RD;
   assign c2fReq.requestorId = tileId;   // Response comes back to us

   // ============================================================
   // Outstanding read tracking
   // ============================================================
   assign rspValid = outstanding && inFabricValid && (inFabric.opcode == fabricPkg::RD_RSP);

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         outstanding  <= 1'b0;
         rspValidQ    <= 1'b0;
         whoAmIQ      <= 1'b0;
         sampleReadyQ <= 1'b1;
      end else begin
         if (rspValid)
            outstanding <= 1'b0;                     // Response wins
         else if (c2fPush && dReq.rdEn)
            outstanding <= 1'b1;
         rspValidQ    <= rspValid;
         whoAmIQ      <= isWhoAmI;
         sampleReadyQ <= dMemReady;
      end
   end

   assign dMemReady = !outstanding && !c2fFull;      // Back-pressure to the core

   // ============================================================
   // Read response
   // ============================================================
   always_ff @(posedge Clock) begin
      rspDataQ <= inFabric.data;
      byteSelQ <= dReq.addr.regionView.byteSel;
      if (sampleReadyQ) lastRamQ <= dRamRdData;   // Held across stall
      if (dMemReady)    dMemRdRsp <= preRsp;      // Second read cycle
   end

   assign ramWord = sampleReadyQ ? dRamRdData : lastRamQ;

   always_comb begin
      if (rspValidQ)
         preRsp = rspDataQ;                             // Remote read data
      else if (whoAmIQ)
         preRsp = {{(`DATA_W-`TILE_ID_W){1'b0}}, tileId};
      else
         preRsp = ramWord >> {byteSelQ, 3'b000};        // Right-aligned, zero fill
   end

endmodule

// File: rtl/transFifo.sv
// Push when full and pop when empty are dropped; popData is valid only while not empty
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module transFifo #(
   parameter int depth = `QUEUE_DEPTH
) (
   input  logic                 Clock,
   input  logic                 rstN,
   input  logic                 push,
   input  fabricPkg::tTileTrans pushData,
   input  logic                 pop,
   output fabricPkg::tTileTrans popData,
   output logic                 full,
   output logic                 almostFull,
   output logic                 empty
);

   localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
   localparam int cntW = ptrW + 1;

   fabricPkg::tTileTrans entries [depth];
   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [cntW-1:0] count;     // Occupied entries
   logic            doPush;
   logic            doPop;

   assign doPush = push && !full;
   assign doPop  = pop && !empty;

   // Pointers and count
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush)
            wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;   // Wrap
         if (doPop)
            rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
         count <= count + cntW'(doPush) - cntW'(doPop);
      end
   end

   always_ff @(posedge Clock) begin
      if (doPush)
         entries[wrPtr] <= pushData;
   end

   assign popData    = entries[rdPtr];                 // Head, no pop latency
   assign full       = (count == cntW'(depth));
   assign almostFull = (count >= cntW'(depth - 1));    // One slot left
   assign empty      = (count == '0);

endmodule

// File: rtl/dualPortRam.sv
// No read-write collision handling; a read during a write returns the old word
`timescale 1ns/1ns
`include "memWrap_macros.svh"

module dualPortRam #(
   parameter int idxW = 10
) (
   input  logic               Clock,
   input  logic [idxW-1:0]    idxA,
   input  logic [idxW-1:0]    idxB,
   input  logic [`DATA_W-1:0] wrDataA,
   input  logic [`DATA_W-1:0] wrDataB,
   input  logic [3:0]         byteEnA,
   input  logic [3:0]         byteEnB,
   input  logic               wrEnA,
   input  logic               wrEnB,
   output logic [`DATA_W-1:0] rdDataA,
   output logic [`DATA_W-1:0] rdDataB
);

   logic [`DATA_W-1:0] mem [2**idxW];   // No reset, contents loaded by writes

   always_ff @(posedge Clock) begin
      for (int b = 0; b < 4; b++) begin
         if (wrEnA && byteEnA[b])
            mem[idxA][b*8 +: 8] <= wrDataA[b*8 +: 8];   // Core lane write
         if (wrEnB && byteEnB[b])
            mem[idxB][b*8 +: 8] <= wrDataB[b*8 +: 8];   // Fabric lane write
      end
      rdDataA <= mem[idxA];   // Registered read, one cycle
      rdDataB <= mem[idxB];
   end

endmodule

// File: rtl/corePkg.sv
// Core-side request types; data address uses the fabric address layout
`include "memWrap_macros.svh"

package corePkg;

   // Data memory request, 70 bits
   typedef struct packed {
      fabricPkg::tFabAddr addr;
      logic [`DATA_W-1:0] wrData;    // Right-aligned, shifted by the wrapper
      logic [3:0]         byteEn;    // Right-aligned like wrData
      logic               wrEn;
      logic               rdEn;
   } tDMemReq;

   // Fetch request, 33 bits
   typedef struct packed {
      logic [31:0] pc;
      logic        ready;            // Low stalls the fetched word
   } tFetchReq;

endpackage

// File: rtl/fabricPkg.sv
// Fabric transaction types; the address is decoded either as tile+offset or by region
`include "memWrap_macros.svh"

package fabricPkg;

   // ============================================================
   // Opcodes
   // ============================================================
   typedef enum logic [1:0] {
      RD     = 2'b00,
      WR     = 2'b01,
      RD_RSP = 2'b10
   } tFabOpcode;

   // Tile view of an address
   typedef struct packed {
      logic [`TILE_ID_W-1:0] tileId;
      logic [23:0]           offset;     // Byte offset inside the tile
   } tTileView;

   // Region view, same 32 bits
   typedef struct packed {
      logic [`TILE_ID_W-1:0] tileId;
      logic [3:0]            region;     // IMEM or DMEM
      logic [9:0]            wordIdx;    // Word index inside the region
      logic [7:0]            spare;
      logic [1:0]            byteSel;    // Byte inside the word
   } tRegionView;

   typedef union packed {
      tTileView   tileView;
      tRegionView regionView;
   } tFabAddr;

   // One fabric transaction, 74 bits
   typedef struct packed {
      tFabAddr               address;
      logic [`DATA_W-1:0]    data;
      tFabOpcode             opcode;
      logic [`TILE_ID_W-1:0] requestorId; // Tile that issued the request
   } tTileTrans;

   typedef logic [3:0] tFabReady;        // One bit per neighbour link

endpackage

// File: rtl/memWrap_macros.svh
// Widths and depths are fixed here; both memories are word-indexed, 1024 words each
`ifndef MEMWRAP_MACROS_SVH
`define MEMWRAP_MACROS_SVH

// ============================================================
// Data path widths
// ============================================================
`define DATA_W        32            // Fabric and core data word
`define TILE_ID_W     8             // Tile id in the address MSBs

// ============================================================
// Memory geometry and address map
// ============================================================
`define IMEM_IDX_W    10            // Instruction memory word index
`define DMEM_IDX_W    10            // Data memory word index
`define REGION_IMEM   4'd0
`define REGION_DMEM   4'd1
`define WHOAMI_OFFSET 24'hFFFFFF    // Tile 0 offset that returns the local id

// Outbound queue depth, per stream
`define QUEUE_DEPTH   2

`endif
